// File: vlog.f
+incdir+dv
common/idu_pkg.sv
source/gpr_file.sv
idu/idu_decode.sv
idu/idu_imm_gen.sv
idu/idu_stage.sv
dv/idu_chk.sv
dv/tb_idu.sv

// File: Bender.yml
package:
  name: idu

sources:
  - common/idu_pkg.sv
  - source/gpr_file.sv
  - idu/idu_decode.sv
  - idu/idu_imm_gen.sv
  - idu/idu_stage.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/idu_chk.sv
      - dv/tb_idu.sv

// File: dv/idu_ref_model.svh
// reference decode and register shadow for the decode stage, included inside the testbench module
`ifndef IDU_REF_MODEL_SVH
`define IDU_REF_MODEL_SVH

// expected decode of one instruction word
logic            exp_illegal;
logic            exp_wr_gpr;
logic            exp_wr_csr;
logic            exp_mem_rd;
logic            exp_mem_wr;
logic            exp_mem_uns;
alu_op_e         exp_alu_op;
alu_src1_e       exp_src1;
alu_src2_e       exp_src2;
mem_size_e       exp_mem_size;
br_cmp_e         exp_cmp;
jump_base_e      exp_jb;
sys_op_e         exp_sys;
logic [XLEN-1:0] exp_imm;

// register file contents as seen from the next cycle on
logic [XLEN-1:0] shadow [NUM_GPR];

// bit 30 picks sub on register ops and sra on both
function automatic alu_op_e funct3_alu(input logic [2:0] f3, input logic alt, input logic is_reg);
    case (f3)
        3'd0: return (alt && is_reg) ? SUB : ADD;
        3'd1: return SLL;
        3'd2: return SLT;
        3'd3: return SLTU;
        3'd4: return XOR;
        3'd5: return alt ? SRA : SRL;
        3'd6: return OR;
        default: return AND;
    endcase
endfunction

task automatic predict_decode(input logic [XLEN-1:0] w);
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic            ok;
    logic            use_rd;
    logic            use_rs1;
    logic            use_rs2;
    mem_size_e       size;
    logic [XLEN-1:0] imm_i;
    f3    = w[14:12];
    f7    = w[31:25];
    size  = (f3[1:0] == 2'd0) ? MEM_BYTE : (f3[1:0] == 2'd1) ? MEM_HALF : MEM_WORD;
    imm_i = {{20{w[31]}}, w[31:20]};
    {exp_wr_gpr, exp_wr_csr, exp_mem_rd, exp_mem_wr, exp_mem_uns} = '0;
    {ok, use_rd, use_rs1, use_rs2} = '0;
    exp_alu_op   = ADD;
    exp_src1     = SRC1_RS1;
    exp_src2     = SRC2_RS2;
    exp_mem_size = MEM_WORD;
    exp_cmp      = CMP_NONE;
    exp_jb       = JB_NONE;
    exp_sys      = SYS_NONE;
    exp_imm      = '0;
    case (w[6:0])
        OP_LUI, OP_AUIPC: begin
            {ok, use_rd, exp_wr_gpr} = 3'b111;
            exp_src2   = SRC2_IMM;
            exp_imm    = {w[31:12], 12'h000};
            exp_alu_op = (w[6:0] == OP_LUI) ? PASS : ADD;
            exp_src1   = (w[6:0] == OP_LUI) ? SRC1_RS1 : SRC1_PC;
        end
        OP_JAL, OP_JALR: begin
            // link value is pc plus four
            ok         = (w[6:0] == OP_JAL) || (f3 == 3'd0);
            use_rd     = 1'b1;
            use_rs1    = (w[6:0] == OP_JALR);
            exp_wr_gpr = 1'b1;
            exp_src1   = SRC1_PC;
            exp_src2   = SRC2_FOUR;
            exp_jb     = (w[6:0] == OP_JAL) ? JB_PC : JB_RS1;
            exp_imm    = (w[6:0] == OP_JAL) ? {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0}
                                            : imm_i;
        end
        OP_BRANCH: begin
            ok         = (f3 != 3'd2) && (f3 != 3'd3);
            {use_rs1, use_rs2} = 2'b11;
            exp_jb     = JB_PC;
            exp_alu_op = f3[1] ? SLTU : SLT;
            exp_imm    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            case (f3)
                3'd0: exp_cmp = CMP_EQ;
                3'd1: exp_cmp = CMP_NE;
                3'd4: exp_cmp = CMP_LT;
                3'd5: exp_cmp = CMP_GE;
                3'd6: exp_cmp = CMP_LTU;
                3'd7: exp_cmp = CMP_GEU;
                default: exp_cmp = CMP_NONE;
            endcase
        end
        OP_LOAD: begin
            ok = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            {use_rd, use_rs1, exp_mem_rd, exp_wr_gpr} = 4'b1111;
            exp_mem_size = size;
            exp_mem_uns  = f3[2];
            exp_src2     = SRC2_IMM;
            exp_imm      = imm_i;
        end
        OP_STORE: begin
            ok = (f3 < 3'd3);
            {use_rs1, use_rs2, exp_mem_wr} = 3'b111;
            exp_mem_size = size;
            exp_src2     = SRC2_IMM;
            exp_imm      = {{20{w[31]}}, w[31:25], w[11:7]};
        end
        OP_IMM: begin
            {use_rd, use_rs1, exp_wr_gpr} = 3'b111;
            exp_src2   = SRC2_IMM;
            exp_imm    = imm_i;
            exp_alu_op = funct3_alu(f3, w[30], 1'b0);
            ok = (f3 == 3'd1) ? (f7 == 7'h00) : (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        end
        OP_REG: begin
            {use_rd, use_rs1, use_rs2, exp_wr_gpr} = 4'b1111;
            exp_alu_op = funct3_alu(f3, w[30], 1'b1);
            ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end
        OP_SYSTEM: begin
            exp_imm = imm_i;
            if (w == 32'h0000_0073) begin
                {ok, exp_wr_csr} = 2'b11;
                exp_sys = SYS_ECALL;
                exp_jb  = JB_CSR;
            end else if (w == 32'h0010_0073) begin
                ok      = 1'b1;
                exp_sys = SYS_EBREAK;
            end else if (w == 32'h3020_0073) begin
                // mret carries no immediate
                ok      = 1'b1;
                exp_sys = SYS_MRET;
                exp_jb  = JB_CSR;
                exp_imm = '0;
            end else if (f3 == 3'd1 || f3 == 3'd2) begin
                {ok, use_rd, use_rs1, exp_wr_gpr, exp_wr_csr} = 5'b11111;
                exp_alu_op = PASS;
                exp_src2   = SRC2_CSR;
                exp_sys    = f3[1] ? SYS_CSRRS : SYS_CSRRW;
            end
        end
        default: ok = 1'b0;
    endcase
    // x16 and up do not exist in RV32E
    exp_illegal = !ok || (use_rd && w[11]) || (use_rs1 && w[19]) || (use_rs2 && w[24]);
    if (exp_illegal) begin
        {exp_wr_gpr, exp_wr_csr, exp_mem_rd, exp_mem_wr} = '0;
        exp_cmp = CMP_NONE;
        exp_jb  = JB_NONE;
        exp_sys = SYS_NONE;
    end
endtask

`endif

// File: dv/tb_idu.sv
// testbench for the decode stage that checks random stimulus cycle by cycle against a reference model
module tb_idu import idu_pkg::*; ();

    logic                 clk = 1'b0;
    logic                 reset_i;
    logic                 inst_valid_i;
    logic [XLEN-1:0]      inst_i;
    logic [XLEN-1:0]      pc_i;
    logic                 stall_i;
    logic                 flush_i;
    logic                 wb_en_i;
    logic [GPR_AW-1:0]    wb_rd_i;
    logic [XLEN-1:0]      wb_data_i;
    logic                 dec_valid_o;
    logic [XLEN-1:0]      pc_o;
    alu_op_e              alu_op_o;
    alu_src1_e            alu_src1_o;
    alu_src2_e            alu_src2_o;
    logic [INST_RD_W-1:0] rd_o;
    logic [INST_RD_W-1:0] rs1_o;
    logic [INST_RD_W-1:0] rs2_o;
    logic [CSR_AW-1:0]    csr_id_o;
    logic                 write_gpr_o;
    logic                 write_csr_o;
    logic                 mem_read_o;
    logic                 mem_write_o;
    logic                 mem_unsigned_o;
    mem_size_e            mem_size_o;
    br_cmp_e              br_cmp_o;
    jump_base_e           jump_base_o;
    sys_op_e              sys_op_o;
    logic                 illegal_o;
    logic [XLEN-1:0]      imm_o;
    logic [XLEN-1:0]      rs1_data_o;
    logic [XLEN-1:0]      rs2_data_o;
    logic                 halt_o;

    // model of the stage state after each rising edge
    logic            m_valid;
    logic            m_halt;
    logic [XLEN-1:0] m_inst;
    logic [XLEN-1:0] m_pc;
    int              n_checks = 0;
    int              n_errors = 0;
    int              n_timeouts = 0;

    `include "idu_ref_model.svh"

    always #50 clk = ~clk;

    idu_stage i_dut (.*);

    // ==================================================
    // checking
    // ==================================================
    task automatic check_equal(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_equal("dec_valid_o", dec_valid_o, m_valid);
        check_equal("halt_o", halt_o, m_halt);
        if (!m_valid) begin
            check_equal("side effects while idle",
                        {write_gpr_o, write_csr_o, mem_read_o, mem_write_o}, 4'b0000);
        end else begin
            predict_decode(m_inst);
            check_equal("pc_o", pc_o, m_pc);
            check_equal("illegal_o", illegal_o, exp_illegal);
            check_equal("write_gpr_o", write_gpr_o, exp_wr_gpr);
            check_equal("write_csr_o", write_csr_o, exp_wr_csr);
            check_equal("mem_read_o", mem_read_o, exp_mem_rd);
            check_equal("mem_write_o", mem_write_o, exp_mem_wr);
            check_equal("br_cmp_o", br_cmp_o, exp_cmp);
            check_equal("jump_base_o", jump_base_o, exp_jb);
            check_equal("sys_op_o", sys_op_o, exp_sys);
            check_equal("rs1_o", rs1_o, m_inst[19:15]);
            check_equal("rs2_o", rs2_o, m_inst[24:20]);
            check_equal("csr_id_o", csr_id_o, m_inst[31:20]);
            check_equal("rs1_data_o", rs1_data_o, shadow[m_inst[18:15]]);
            check_equal("rs2_data_o", rs2_data_o, shadow[m_inst[23:20]]);
            if (!exp_illegal) begin
                check_equal("alu_op_o", alu_op_o, exp_alu_op);
                check_equal("alu_src1_o", alu_src1_o, exp_src1);
                check_equal("alu_src2_o", alu_src2_o, exp_src2);
                check_equal("imm_o", imm_o, exp_imm);
                check_equal("rd_o", rd_o, m_inst[11:7]);
                if (exp_mem_rd || exp_mem_wr) begin
                    check_equal("mem_size_o", mem_size_o, exp_mem_size);
                    check_equal("mem_unsigned_o", mem_unsigned_o, exp_mem_uns);
                end
            end
        end
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    task automatic apply_reset();
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        stall_i      = 1'b0;
        flush_i      = 1'b0;
        wb_en_i      = 1'b0;
        wb_rd_i      = '0;
        wb_data_i    = '0;
        m_valid      = 1'b0;
        m_halt       = 1'b0;
        for (int i = 0; i < NUM_GPR; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
    endtask

    // checks the last edge, drives the next one and advances the model across it
    task automatic step_cycle(input logic iv, input logic [XLEN-1:0] word, input logic st,
                              input logic fl, input logic we);
        logic cap;
        @(negedge clk);
        compare_outputs();
        inst_valid_i = iv;
        inst_i       = word;
        pc_i         = $urandom & 32'hffff_fffc;
        stall_i      = st;
        flush_i      = fl;
        wb_en_i      = we;
        wb_rd_i      = $urandom % NUM_GPR;
        wb_data_i    = $urandom;
        cap = iv && !st && !fl && !m_halt;
        if (m_valid) begin
            predict_decode(m_inst);
            if (exp_sys == SYS_EBREAK) m_halt = 1'b1;
        end
        if (fl) begin
            m_valid = 1'b0;
        end else if (!st) begin
            m_valid = cap;
        end
        if (cap) begin
            m_inst = word;
            m_pc   = pc_i;
        end
        if (we && wb_rd_i != '0) shadow[wb_rd_i] = wb_data_i;
    endtask

    // picks one class at random and leaves ebreak out so the run keeps going
    function automatic logic [XLEN-1:0] random_legal_word();
        logic [XLEN-1:0] w;
        w = $urandom;
        case ($urandom % 10)
            0: w[6:0] = OP_LUI;
            1: w[6:0] = OP_AUIPC;
            2: w[6:0] = OP_JAL;
            3: {w[14:12], w[6:0]} = {3'b000, OP_JALR};
            4: begin
                w[6:0] = OP_BRANCH;
                if (w[14:13] == 2'b01) w[14] = 1'b1;
            end
            5: begin
                w[6:0] = OP_LOAD;
                if (w[13:12] == 2'b11 || w[14:13] == 2'b11) w[13] = 1'b0;
            end
            6: begin
                w[6:0] = OP_STORE;
                w[14]  = 1'b0;
                if (w[13:12] == 2'b11) w[12] = 1'b0;
            end
            7: begin
                w[6:0] = OP_IMM;
                if (w[13:12] == 2'b01) w[31:25] = {1'b0, w[30] & w[14], 5'b0};
            end
            8: begin
                w[6:0]   = OP_REG;
                w[31:25] = (w[14:12] == 3'b000 || w[14:12] == 3'b101)
                           ? {1'b0, w[30], 5'b0} : '0;
            end
            default: begin
                if (w[1:0] == 2'b00) w = 32'h0000_0073;
                else if (w[1:0] == 2'b01) w = 32'h3020_0073;
                else {w[14:12], w[6:0]} = {1'b0, w[13], !w[13], OP_SYSTEM};
            end
        endcase
        // keep every register field inside x0..x15
        {w[24], w[19], w[11]} = 3'b000;
        return w;
    endfunction

    function automatic logic [XLEN-1:0] random_illegal_word();
        logic [XLEN-1:0] w;
        w = random_legal_word();
        case ($urandom % 5)
            // compressed encodings are not supported
            0: w[1:0] = 2'b00;
            1: {w[14:12], w[6:0]} = {3'b010, OP_BRANCH};
            2: {w[31:25], w[6:0]} = {7'b0000001, OP_REG};
            3: {w[31:25], w[24], w[6:0]} = {7'b0000000, 1'b1, OP_REG};
            default: {w[11], w[6:0]} = {1'b1, OP_JAL};
        endcase
        return w;
    endfunction

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        logic [XLEN-1:0] word;
        int              tries;
        void'($urandom(28));
        apply_reset();
        for (int n = 0; n < 800; n++) begin
            word = ($urandom % 5 == 0) ? random_illegal_word() : random_legal_word();
            step_cycle(($urandom % 100) < 65, word, ($urandom % 100) < 15,
                       ($urandom % 100) < 8, ($urandom % 100) < 40);
        end
        // drain and then send a clean ebreak
        step_cycle(1'b0, '0, 1'b0, 1'b0, 1'b0);
        step_cycle(1'b1, 32'h0010_0073, 1'b0, 1'b0, 1'b0);
        tries = 0;
        while (!halt_o && tries < 10) begin
            step_cycle(1'b0, '0, 1'b0, 1'b0, 1'b0);
            tries++;
        end
        if (!halt_o) begin
            $display("Timeout: halt_o did not rise after a valid ebreak");
            n_timeouts++;
        end
        // strobes after the halt must be dropped
        for (int n = 0; n < 20; n++) begin
            step_cycle(1'b1, random_legal_word(), 1'b0, 1'b0, ($urandom % 2) == 1);
        end
        apply_reset();
        for (int n = 0; n < 100; n++) begin
            step_cycle(($urandom % 100) < 65, random_legal_word(), ($urandom % 100) < 15,
                       ($urandom % 100) < 8, ($urandom % 100) < 40);
        end
        step_cycle(1'b0, '0, 1'b0, 1'b0, 1'b0);
        step_cycle(1'b0, '0, 1'b0, 1'b0, 1'b0);
        $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: dv/idu_chk.sv
// concurrent assertions on stage invariants that are bound into every decode stage instance
module idu_chk (
    input logic clk,
    input logic reset_i,
    input logic stall_i,
    input logic halt_i,
    input logic dec_valid_i,
    input logic mem_write_i,
    input logic write_gpr_i
);

    // decode register comes out of reset empty
    a_valid_after_reset: assert property (@(posedge clk) reset_i |=> !dec_valid_i)
        else $error("dec_valid_o high in the cycle after reset");

    // an unstalled cycle of a halted stage leaves the decode register empty
    a_no_capture_halted: assert property (
        @(posedge clk) disable iff (reset_i) halt_i && !stall_i |=> !dec_valid_i
    ) else $error("instruction captured while halt_o is high");

    // no instruction both stores and writes a register
    a_store_no_writeback: assert property (
        @(posedge clk) disable iff (reset_i) !(mem_write_i && write_gpr_i)
    ) else $error("mem_write_o and write_gpr_o high together");

endmodule

bind idu_stage idu_chk i_chk (
    .clk        (clk),
    .reset_i    (reset_i),
    .stall_i    (stall_i),
    .halt_i     (halt_o),
    .dec_valid_i(dec_valid_o),
    .mem_write_i(mem_write_o),
    .write_gpr_i(write_gpr_o)
);

// File: idu/idu_stage.sv
// decode stage top, captures a fetched word and presents its decode and operands to execute
module idu_stage import idu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 inst_valid_i,
    input  logic [XLEN-1:0]      inst_i,
    input  logic [XLEN-1:0]      pc_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    input  logic                 wb_en_i,
    input  logic [GPR_AW-1:0]    wb_rd_i,
    input  logic [XLEN-1:0]      wb_data_i,
    output logic                 dec_valid_o,
    output logic [XLEN-1:0]      pc_o,
    output alu_op_e              alu_op_o,
    output alu_src1_e            alu_src1_o,
    output alu_src2_e            alu_src2_o,
    output logic [INST_RD_W-1:0] rd_o,
    output logic [INST_RD_W-1:0] rs1_o,
    output logic [INST_RD_W-1:0] rs2_o,
    output logic [CSR_AW-1:0]    csr_id_o,
    output logic                 write_gpr_o,
    output logic                 write_csr_o,
    output logic                 mem_read_o,
    output logic                 mem_write_o,
    output logic                 mem_unsigned_o,
    output mem_size_e            mem_size_o,
    output br_cmp_e              br_cmp_o,
    output jump_base_e           jump_base_o,
    output sys_op_e              sys_op_o,
    output logic                 illegal_o,
    output logic [XLEN-1:0]      imm_o,
    output logic [XLEN-1:0]      rs1_data_o,
    output logic [XLEN-1:0]      rs2_data_o,
    output logic                 halt_o
);

    logic [XLEN-1:0] inst_q;
    logic            valid_q;
    logic            halt_q;
    logic            capture;
    inst_fmt_e       dec_fmt;
    logic            dec_wr_gpr, dec_wr_csr, dec_rd_mem, dec_wr_mem;

    // ==================================================
    // decode register
    // ==================================================
    assign capture = inst_valid_i && !stall_i && !flush_i && !halt_q;

    always_ff @(posedge clk) begin
        if (capture) begin
            inst_q <= inst_i;
            pc_o   <= pc_i;
        end
    end

    // flush first, then stall holds, otherwise valid for one cycle per capture
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= capture;
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            halt_q <= 1'b0;
        end else if (valid_q && sys_op_o == SYS_EBREAK) begin
            halt_q <= 1'b1;
        end
    end

    assign dec_valid_o = valid_q;
    assign halt_o      = halt_q;

    // ==================================================
    // decode, immediate and register read
    // ==================================================
    idu_decode i_decode (
        .inst_i        (inst_q),
        .fmt_o         (dec_fmt),
        .alu_op_o      (alu_op_o),
        .alu_src1_o    (alu_src1_o),
        .alu_src2_o    (alu_src2_o),
        .rd_o          (rd_o),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .csr_id_o      (csr_id_o),
        .write_gpr_o   (dec_wr_gpr),
        .write_csr_o   (dec_wr_csr),
        .mem_read_o    (dec_rd_mem),
        .mem_write_o   (dec_wr_mem),
        .mem_unsigned_o(mem_unsigned_o),
        .mem_size_o    (mem_size_o),
        .br_cmp_o      (br_cmp_o),
        .jump_base_o   (jump_base_o),
        .sys_op_o      (sys_op_o),
        .illegal_o     (illegal_o)
    );

    idu_imm_gen i_imm_gen (
        .inst_i(inst_q),
        .fmt_i (dec_fmt),
        .imm_o (imm_o)
    );

    // low 4 bits index the file, bit 4 is caught as illegal
    gpr_file i_gpr_file (
        .clk       (clk),
        .reset_i   (reset_i),
        .rs1_i     (rs1_o[GPR_AW-1:0]),
        .rs2_i     (rs2_o[GPR_AW-1:0]),
        .rs1_data_o(rs1_data_o),
        .rs2_data_o(rs2_data_o),
        .wb_en_i   (wb_en_i),
        .wb_rd_i   (wb_rd_i),
        .wb_data_i (wb_data_i)
    );

    // side effects only in a valid cycle
    assign write_gpr_o = dec_wr_gpr && valid_q;
    assign write_csr_o = dec_wr_csr && valid_q;
    assign mem_read_o  = dec_rd_mem && valid_q;
    assign mem_write_o = dec_wr_mem && valid_q;

endmodule

// File: idu/idu_imm_gen.sv
// builds the sign-extended immediate of the captured instruction from its decoded format
module idu_imm_gen import idu_pkg::*; (
    input  logic [XLEN-1:0] inst_i,
    input  inst_fmt_e       fmt_i,
    output logic [XLEN-1:0] imm_o
);

    logic sign;

    // bit 31 is the sign in every format
    assign sign = inst_i[31];

    always_comb begin
        case (fmt_i)
            FMT_I: begin
                imm_o = {{20{sign}}, inst_i[31:20]};
            end
            FMT_S: begin
                imm_o = {{20{sign}}, inst_i[31:25], inst_i[11:7]};
            end
            FMT_B: begin
                // offset in halfwords, bit 0 implied
                imm_o = {{19{sign}}, sign, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
            end
            FMT_U: begin
                imm_o = {inst_i[31:12], 12'b0};
            end
            FMT_J: begin
                imm_o = {{11{sign}}, sign, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            end
            default: begin
                // r type and unknown words carry no immediate
                imm_o = '0;
            end
        endcase
    end

endmodule

// File: idu/idu_decode.sv
// combinational RV32E decoder, turns an instruction word into control enums, flags and indices
module idu_decode import idu_pkg::*; (
    input  logic [XLEN-1:0]      inst_i,
    output inst_fmt_e            fmt_o,
    output alu_op_e              alu_op_o,
    output alu_src1_e            alu_src1_o,
    output alu_src2_e            alu_src2_o,
    output logic [INST_RD_W-1:0] rd_o,
    output logic [INST_RD_W-1:0] rs1_o,
    output logic [INST_RD_W-1:0] rs2_o,
    output logic [CSR_AW-1:0]    csr_id_o,
    output logic                 write_gpr_o,
    output logic                 write_csr_o,
    output logic                 mem_read_o,
    output logic                 mem_write_o,
    output logic                 mem_unsigned_o,
    output mem_size_e            mem_size_o,
    output br_cmp_e              br_cmp_o,
    output jump_base_e           jump_base_o,
    output sys_op_e              sys_op_o,
    output logic                 illegal_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       known;
    logic       use_rd, use_rs1, use_rs2;
    logic       bad_reg;
    logic       wr_gpr, wr_csr, rd_mem, wr_mem;
    br_cmp_e    br_cmp;
    jump_base_e jump_base;
    sys_op_e    sys_op;

    assign funct3   = inst_i[14:12];
    assign funct7   = inst_i[31:25];
    assign rd_o     = inst_i[11:7];
    assign rs1_o    = inst_i[19:15];
    assign rs2_o    = inst_i[24:20];
    assign csr_id_o = inst_i[31:20];

    // ==================================================
    // opcode and funct decode
    // ==================================================
    always_comb begin
        fmt_o          = FMT_NONE;
        alu_op_o       = ADD;
        alu_src1_o     = SRC1_RS1;
        alu_src2_o     = SRC2_RS2;
        mem_size_o     = MEM_WORD;
        mem_unsigned_o = 1'b0;
        wr_gpr         = 1'b0;
        wr_csr         = 1'b0;
        rd_mem         = 1'b0;
        wr_mem         = 1'b0;
        br_cmp         = CMP_NONE;
        jump_base      = JB_NONE;
        sys_op         = SYS_NONE;
        known          = 1'b0;
        use_rd         = 1'b0;
        use_rs1        = 1'b0;
        use_rs2        = 1'b0;

        case (opcode_e'(inst_i[6:0]))
            OP_IMM, OP_REG: begin
                fmt_o      = inst_i[5] ? FMT_R : FMT_I;
                alu_src2_o = inst_i[5] ? SRC2_RS2 : SRC2_IMM;
                wr_gpr     = 1'b1;
                {use_rd, use_rs1, use_rs2} = {2'b11, inst_i[5]};
                // funct7 only qualifies shifts on OP_IMM, and everything on OP_REG
                known = (funct7 == 7'b0000000) || (!inst_i[5] && funct3 != 3'b001
                        && funct3 != 3'b101);
                case (funct3)
                    3'b000: alu_op_o = (inst_i[5] && funct7[5]) ? SUB : ADD;
                    3'b001: alu_op_o = SLL;
                    3'b010: alu_op_o = SLT;
                    3'b011: alu_op_o = SLTU;
                    3'b100: alu_op_o = XOR;
                    3'b101: alu_op_o = funct7[5] ? SRA : SRL;
                    3'b110: alu_op_o = OR;
                    default: alu_op_o = AND;
                endcase
                // sub and sra are the only other funct7 values
                if (funct7 == 7'b0100000 && (funct3 == 3'b101 || (inst_i[5] && funct3 == 3'b000)))
                    known = 1'b1;
            end
            OP_LOAD: begin
                fmt_o          = FMT_I;
                alu_src2_o     = SRC2_IMM;
                rd_mem         = 1'b1;
                wr_gpr         = 1'b1;
                mem_size_o     = mem_size_e'(funct3[1:0]);
                mem_unsigned_o = funct3[2];
                known          = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
                {use_rd, use_rs1} = 2'b11;
            end
            OP_STORE: begin
                fmt_o      = FMT_S;
                alu_src2_o = SRC2_IMM;
                wr_mem     = 1'b1;
                mem_size_o = mem_size_e'(funct3[1:0]);
                known      = (funct3 inside {3'b000, 3'b001, 3'b010});
                {use_rs1, use_rs2} = 2'b11;
            end
            OP_BRANCH: begin
                fmt_o     = FMT_B;
                alu_op_o  = funct3[1] ? SLTU : SLT;
                jump_base = JB_PC;
                known     = (funct3[2:1] != 2'b01);
                {use_rs1, use_rs2} = 2'b11;
                case (funct3)
                    3'b000: br_cmp = CMP_EQ;
                    3'b001: br_cmp = CMP_NE;
                    3'b100: br_cmp = CMP_LT;
                    3'b101: br_cmp = CMP_GE;
                    3'b110: br_cmp = CMP_LTU;
                    default: br_cmp = CMP_GEU;
                endcase
            end
            OP_JAL, OP_JALR: begin
                fmt_o      = inst_i[3] ? FMT_J : FMT_I;
                alu_src1_o = SRC1_PC;
                alu_src2_o = SRC2_FOUR;
                wr_gpr     = 1'b1;
                jump_base  = inst_i[3] ? JB_PC : JB_RS1;
                known      = inst_i[3] || (funct3 == 3'b000);
                use_rd     = 1'b1;
                use_rs1    = !inst_i[3];
            end
            OP_LUI, OP_AUIPC: begin
                fmt_o      = FMT_U;
                alu_op_o   = inst_i[5] ? PASS : ADD;
                alu_src1_o = inst_i[5] ? SRC1_RS1 : SRC1_PC;
                alu_src2_o = SRC2_IMM;
                wr_gpr     = 1'b1;
                known      = 1'b1;
                use_rd     = 1'b1;
            end
            OP_SYSTEM: begin
                fmt_o = FMT_I;
                if (funct3 == 3'b000 && inst_i[19:7] == '0) begin
                    known = 1'b1;
                    case (csr_id_o)
                        12'h000: {sys_op, jump_base, wr_csr} = {SYS_ECALL, JB_CSR, 1'b1};
                        12'h001: sys_op = SYS_EBREAK;
                        12'h302: {sys_op, jump_base, fmt_o} = {SYS_MRET, JB_CSR, FMT_R};
                        default: known = 1'b0;
                    endcase
                end else if (funct3 == 3'b001 || funct3 == 3'b010) begin
                    // old csr value goes to rd through the alu
                    alu_op_o   = PASS;
                    alu_src2_o = SRC2_CSR;
                    wr_gpr     = 1'b1;
                    wr_csr     = 1'b1;
                    sys_op     = funct3[1] ? SYS_CSRRS : SYS_CSRRW;
                    known      = 1'b1;
                    {use_rd, use_rs1} = 2'b11;
                end
            end
            default: known = 1'b0;
        endcase
    end

    // ==================================================
    // illegal check and side effect gating
    // ==================================================
    // RV32E has x0..x15 only
    assign bad_reg   = (use_rd && rd_o[4]) || (use_rs1 && rs1_o[4]) || (use_rs2 && rs2_o[4]);
    assign illegal_o = !known || bad_reg;

    assign write_gpr_o = wr_gpr && !illegal_o;
    assign write_csr_o = wr_csr && !illegal_o;
    assign mem_read_o  = rd_mem && !illegal_o;
    assign mem_write_o = wr_mem && !illegal_o;
    assign br_cmp_o    = illegal_o ? CMP_NONE : br_cmp;
    assign jump_base_o = illegal_o ? JB_NONE : jump_base;
    assign sys_op_o    = illegal_o ? SYS_NONE : sys_op;

endmodule

// File: source/gpr_file.sv
// RV32E general register file with two asynchronous reads and one synchronous writeback port
module gpr_file import idu_pkg::*; (
    input  logic              clk,
    input  logic              reset_i,
    input  logic [GPR_AW-1:0] rs1_i,
    input  logic [GPR_AW-1:0] rs2_i,
    output logic [XLEN-1:0]   rs1_data_o,
    output logic [XLEN-1:0]   rs2_data_o,
    input  logic              wb_en_i,
    input  logic [GPR_AW-1:0] wb_rd_i,
    input  logic [XLEN-1:0]   wb_data_i
);

    logic [XLEN-1:0] regs [NUM_GPR];

    // ==================================================
    // write port
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && wb_rd_i != '0) begin
            // x0 is never written
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // ==================================================
    // read ports
    // ==================================================
    // no bypass, a write shows up from the next cycle
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: common/idu_pkg.sv
// shared sizes and control enums for the RV32E decode stage, imported by its modules and testbench
package idu_pkg;

    // ==================================================
    // sizes
    // ==================================================
    localparam int XLEN      = 32;
    localparam int NUM_GPR   = 16;
    localparam int GPR_AW    = 4;
    localparam int INST_RD_W = 5;
    localparam int CSR_AW    = 12;

    // ==================================================
    // major opcodes, bits [6:0] of the instruction
    // ==================================================
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // ==================================================
    // control encodings towards execute
    // ==================================================
    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA,
        // operand 2 straight through, for lui and csr reads
        PASS
    } alu_op_e;

    typedef enum logic [0:0] {SRC1_RS1, SRC1_PC} alu_src1_e;

    typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR, SRC2_CSR} alu_src2_e;

    // immediate layout, shared by decoder and immediate generator
    typedef enum logic [2:0] {FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_NONE} inst_fmt_e;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

    typedef enum logic [2:0] {
        CMP_NONE, CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
    } br_cmp_e;

    // jal and branches use pc, jalr uses rs1, ecall and mret use a csr
    typedef enum logic [1:0] {JB_NONE, JB_PC, JB_RS1, JB_CSR} jump_base_e;

    typedef enum logic [2:0] {
        SYS_NONE, SYS_ECALL, SYS_EBREAK, SYS_MRET, SYS_CSRRW, SYS_CSRRS
    } sys_op_e;

endpackage
